//--- src/div_pkg.sv
// divider shared types
`default_nettype none

package div_pkg;

    localparam int xlen = 32;                       // data word width.

    typedef enum logic [1:0] {
        op_div,
        op_divu,
        op_rem,
        op_remu
    } div_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_prep,
        st_iter,
        st_fix
    } div_state_e;

    typedef struct packed {
        logic [xlen-1:0] dividend;
        logic [xlen-1:0] divisor;
        div_op_e         op;
    } div_req_t;

    typedef struct packed {
        logic [xlen-1:0] dividend;                  // magnitude.
        logic [xlen-1:0] divisor;                   // magnitude.
    } div_operands_t;

    typedef struct packed {
        logic neg_quot;
        logic neg_rem;
        logic overflow;                             // most negative / -1.
        logic rem_sel;                              // rem or remu.
    } div_sign_t;

    typedef struct packed {
        logic [xlen-1:0] quotient;
        logic [xlen-1:0] remainder;
        logic            divisor_zero;
    } div_raw_t;

    // APB register map, byte offsets
    localparam logic [4:0] reg_dividend = 5'h00;
    localparam logic [4:0] reg_divisor  = 5'h04;
    localparam logic [4:0] reg_ctrl     = 5'h08;
    localparam logic [4:0] reg_status   = 5'h0C;
    localparam logic [4:0] reg_result   = 5'h10;

endpackage

`default_nettype wire

//--- src/div_apb_regs.sv
// divider APB register block
`timescale 1ns/1ns
`default_nettype none

module div_apb_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4:0]               paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [div_pkg::xlen-1:0] pwdata,
    output logic [div_pkg::xlen-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     busy,
    input  logic                     done,
    input  logic                     divisor_zero,
    input  logic [div_pkg::xlen-1:0] result,
    output logic                     start_req,
    output div_pkg::div_req_t        req
);
    import div_pkg::*;

    logic            access;
    logic            addr_ok;
    logic            ro_write;
    logic            start_write;
    logic            wr_ok;
    logic            done_q;
    logic            dz_q;
    logic [xlen-1:0] result_q;

    assign access = psel & penable;
    assign pready = 1'b1;                           // no wait states.

    always_comb begin
        case (paddr)
            reg_dividend, reg_divisor, reg_ctrl, reg_status, reg_result: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign ro_write    = pwrite & ((paddr == reg_status) | (paddr == reg_result));
    assign start_write = pwrite & (paddr == reg_ctrl) & pwdata[8];

    // a start is refused while a division runs or is about to.
    assign pslverr = access & (~addr_ok | ro_write | (start_write & (busy | start_req)));
    assign wr_ok   = access & pwrite & ~pslverr;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_req <= 1'b0;
        end else begin
            start_req <= wr_ok & start_write;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            case (paddr)
                reg_dividend: req.dividend <= pwdata;
                reg_divisor:  req.divisor  <= pwdata;
                reg_ctrl:     req.op       <= div_op_e'(pwdata[1:0]);
                default: ;
            endcase
        end
    end

    // result and zero flag are captured when done rises.
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q   <= 1'b0;
            dz_q     <= 1'b0;
            result_q <= '0;
        end else begin
            done_q <= done;
            if (done && !done_q) begin
                dz_q     <= divisor_zero;
                result_q <= result;
            end
        end
    end

    always_comb begin
        case (paddr)
            reg_dividend: prdata = req.dividend;
            reg_divisor:  prdata = req.divisor;
            reg_ctrl:     prdata = {{(xlen-2){1'b0}}, req.op};
            reg_status:   prdata = {{(xlen-3){1'b0}}, dz_q, done, busy};
            reg_result:   prdata = result_q;
            default:      prdata = '0;
        endcase
    end

    a_penable_in_sel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

`default_nettype wire

//--- src/div_control.sv
// divider sequencing FSM
`timescale 1ns/1ns
`default_nettype none

module div_control (
    input  logic clk,
    input  logic rst,
    input  logic start_req,
    input  logic core_done,
    output logic prep_en,
    output logic core_start,
    output logic fix_en,
    output logic busy,
    output logic done
);
    import div_pkg::*;

    div_state_e state;

    assign busy = (state != st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            prep_en    <= 1'b0;
            core_start <= 1'b0;
            fix_en     <= 1'b0;
            done       <= 1'b0;
        end else begin
            prep_en    <= 1'b0;                     // strobes last one cycle.
            core_start <= 1'b0;
            fix_en     <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_req) begin
                        state   <= st_prep;
                        prep_en <= 1'b1;
                        done    <= 1'b0;            // done holds until the next start.
                    end
                end
                st_prep: begin
                    state      <= st_iter;          // operands load during prep_en.
                    core_start <= 1'b1;
                end
                st_iter: begin
                    if (core_done) begin
                        state  <= st_fix;
                        fix_en <= 1'b1;
                    end
                end
                st_fix: begin
                    state <= st_idle;
                    done  <= 1'b1;                  // result registers on this edge.
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // core only reports completion while the FSM waits for it
    a_done_in_iter: assert property (
        @(posedge clk) disable iff (rst) core_done |-> (state == st_iter)
    );

endmodule

`default_nettype wire

//--- src/div_operand_prep.sv
// divider operand preparation
`timescale 1ns/1ns
`default_nettype none

module div_operand_prep (
    input  logic                   clk,
    input  logic                   prep_en,
    input  div_pkg::div_req_t      req,
    output div_pkg::div_operands_t operands,
    output div_pkg::div_sign_t     sign
);
    import div_pkg::*;

    logic signed_op;
    logic dividend_neg;
    logic divisor_neg;
    logic overflow;

    assign signed_op    = (req.op == op_div) | (req.op == op_rem);
    assign dividend_neg = signed_op & req.dividend[xlen-1];
    assign divisor_neg  = signed_op & req.divisor[xlen-1];

    // most negative dividend over minus one.
    assign overflow = signed_op
                    & (req.dividend == {1'b1, {(xlen-1){1'b0}}})
                    & (&req.divisor);

    always_ff @(posedge clk) begin
        if (prep_en) begin
            operands.dividend <= dividend_neg ? -req.dividend : req.dividend;
            operands.divisor  <= divisor_neg ? -req.divisor : req.divisor;
            sign.neg_quot     <= dividend_neg ^ divisor_neg;
            sign.neg_rem      <= dividend_neg;   // remainder follows the dividend.
            sign.overflow     <= overflow;
            sign.rem_sel      <= (req.op == op_rem) | (req.op == op_remu);
        end
    end

endmodule

`default_nettype wire

//--- src/div_radix4_core.sv
// unsigned radix-4 divider core
// early termination once the rest of the dividend is below the divisor
`timescale 1ns/1ns
`default_nettype none

module div_radix4_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  div_pkg::div_operands_t operands,
    output div_pkg::div_raw_t      raw,
    output logic                   done
);
    import div_pkg::*;

    logic [xlen-1:0]   pr;                          // partial remainder.
    logic [xlen-1:0]   ar;                          // unconsumed dividend bits, msb aligned.
    logic [xlen-1:0]   q;
    logic [xlen-1:0]   b;
    logic [xlen+1:0]   b_x3;
    logic [3:0]        count;                       // radix-4 steps taken.
    logic              active;
    logic              dz;

    logic [xlen+1:0]   pr_shift;
    logic [xlen+2:0]   diff1;
    logic [xlen+2:0]   diff2;
    logic [xlen+2:0]   diff3;
    logic [1:0]        digit;
    logic [xlen-1:0]   pr_next;
    logic [2*xlen-1:0] combined;
    logic [5:0]        q_shift;
    logic              early;
    logic              last;
    logic              finish;

    assign pr_shift = {pr, ar[xlen-1:xlen-2]};
    assign diff1    = {1'b0, pr_shift} - {3'b000, b};
    assign diff2    = {1'b0, pr_shift} - {2'b00, b, 1'b0};
    assign diff3    = {1'b0, pr_shift} - {1'b0, b_x3};

    // largest multiple that does not borrow sets the digit.
    always_comb begin
        if (!diff3[xlen+2]) begin
            digit   = 2'd3;
            pr_next = diff3[xlen-1:0];
        end else if (!diff2[xlen+2]) begin
            digit   = 2'd2;
            pr_next = diff2[xlen-1:0];
        end else if (!diff1[xlen+2]) begin
            digit   = 2'd1;
            pr_next = diff1[xlen-1:0];
        end else begin
            digit   = 2'd0;
            pr_next = pr_shift[xlen-1:0];
        end
    end

    // remainder if every remaining digit were zero.
    assign combined = {pr, ar} >> {count, 1'b0};
    assign early    = combined < {{xlen{1'b0}}, b};
    assign q_shift  = 6'(xlen) - {1'b0, count, 1'b0};
    assign last     = (count == 4'd15);
    assign finish   = early | last;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= active & finish;
            if (start) begin
                active <= 1'b1;
            end else if (active && finish) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pr    <= '0;
            ar    <= operands.dividend;
            q     <= '0;
            b     <= operands.divisor;
            b_x3  <= {1'b0, operands.divisor, 1'b0} + {2'b00, operands.divisor};
            count <= '0;
            dz    <= ~operands.divisor[0];
        end else if (active) begin
            if (early) begin
                raw.quotient     <= q << q_shift;   // skipped digits are zero.
                raw.remainder    <= combined[xlen-1:0];
                raw.divisor_zero <= 1'b0;
            end else begin
                pr    <= pr_next;
                ar    <= {ar[xlen-3:0], 2'b00};
                q     <= {q[xlen-3:0], digit};
                count <= count + 4'd1;
                // zero divisor: even and no 3x subtraction ever borrows
                dz    <= dz & ~diff3[xlen+2];
                if (last) begin
                    raw.quotient     <= {q[xlen-3:0], digit};
                    raw.remainder    <= pr_next;
                    raw.divisor_zero <= dz & ~diff3[xlen+2];
                end
            end
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

`default_nettype wire

//--- src/div_result_fix.sv
// divider result fix-up
`timescale 1ns/1ns
`default_nettype none

module div_result_fix (
    input  logic                     clk,
    input  logic                     fix_en,
    input  div_pkg::div_raw_t        raw,
    input  div_pkg::div_sign_t       sign,
    output logic [div_pkg::xlen-1:0] result,
    output logic                     divisor_zero
);
    import div_pkg::*;

    logic [xlen-1:0] quot_signed;
    logic [xlen-1:0] rem_signed;

    assign quot_signed = sign.neg_quot ? -raw.quotient : raw.quotient;

    // with a zero divisor this rebuilds the original dividend.
    assign rem_signed = sign.neg_rem ? -raw.remainder : raw.remainder;

    always_ff @(posedge clk) begin
        if (fix_en) begin
            divisor_zero <= raw.divisor_zero;
            if (raw.divisor_zero) begin
                if (sign.rem_sel) begin
                    result <= rem_signed;
                end else begin
                    result <= '1;                   // all ones quotient.
                end
            end else if (sign.overflow) begin
                if (sign.rem_sel) begin
                    result <= '0;
                end else begin
                    result <= {1'b1, {(xlen-1){1'b0}}};  // dividend comes back.
                end
            end else if (sign.rem_sel) begin
                result <= rem_signed;
            end else begin
                result <= quot_signed;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/div_top.sv
// APB integer divider
`timescale 1ns/1ns
`default_nettype none

module div_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4:0]               paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [div_pkg::xlen-1:0] pwdata,
    output logic [div_pkg::xlen-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr
);
    import div_pkg::*;

    logic            start_req;
    logic            prep_en;
    logic            core_start;
    logic            core_done;
    logic            fix_en;
    logic            busy;
    logic            done;
    logic            divisor_zero;
    logic [xlen-1:0] result;
    div_req_t        req;
    div_operands_t   operands;
    div_sign_t       sign;
    div_raw_t        raw;

    div_apb_regs div_apb_regs_inst (
        .clk          (clk),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .busy         (busy),
        .done         (done),
        .divisor_zero (divisor_zero),
        .result       (result),
        .start_req    (start_req),
        .req          (req)
    );

    div_control div_control_inst (
        .clk        (clk),
        .rst        (rst),
        .start_req  (start_req),
        .core_done  (core_done),
        .prep_en    (prep_en),
        .core_start (core_start),
        .fix_en     (fix_en),
        .busy       (busy),
        .done       (done)
    );

    div_operand_prep div_operand_prep_inst (
        .clk      (clk),
        .prep_en  (prep_en),
        .req      (req),
        .operands (operands),
        .sign     (sign)
    );

    div_radix4_core div_radix4_core_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (core_start),
        .operands (operands),
        .raw      (raw),
        .done     (core_done)
    );

    div_result_fix div_result_fix_inst (
        .clk          (clk),
        .fix_en       (fix_en),
        .raw          (raw),
        .sign         (sign),
        .result       (result),
        .divisor_zero (divisor_zero)
    );

endmodule

`default_nettype wire

//--- verification/div_tb.sv
// divider APB testbench
`timescale 1ns/1ns
`default_nettype none

module div_tb;
    import div_pkg::*;

    typedef struct packed {
        logic [xlen-1:0] dividend;
        logic [xlen-1:0] divisor;
        div_op_e         op;
        logic [xlen-1:0] expected;
    } vector_t;

    localparam int half_period = 50;                // 100 ns clock.
    localparam int poll_limit  = 100;
    localparam int ready_limit = 16;
    localparam int random_rows = 40;

    logic            clk;
    logic            rst;
    logic [4:0]      paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [xlen-1:0] pwdata;
    logic [xlen-1:0] prdata;
    logic            pready;
    logic            pslverr;

    vector_t vectors[$];
    int      error_count;
    int      pass_count;
    int      fail_count;

    div_top div_top_inst (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    task automatic finish_run(input bit ok);
        if (ok) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] expected);
        if (got !== expected) begin
            $display("error: %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string label, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s: ok", label);
        end else begin
            fail_count++;
            $display("test %s: FAIL", label);
        end
    endtask

    // setup on one falling edge, access on the next, outputs sampled mid phase
    task automatic apb_transfer(input logic write, input logic [4:0] addr,
                                input logic [xlen-1:0] wdata,
                                output logic [xlen-1:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(half_period / 2);
        while (!pready) begin
            if (waits == ready_limit) begin
                $display("timeout: pready stayed low at offset %h", addr);
                finish_run(1'b0);
            end
            waits++;
            @(negedge clk);
            #(half_period / 2);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [xlen-1:0] data,
                             output logic err);
        logic [xlen-1:0] rdata;
        apb_transfer(1'b1, addr, data, rdata, err);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [xlen-1:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_done(output logic [xlen-1:0] status);
        logic err;
        int   polls;
        polls = 0;
        apb_read(reg_status, status, err);
        while (!status[1]) begin
            if (polls == poll_limit) begin
                $display("timeout: status never reported done");
                finish_run(1'b0);
            end
            polls++;
            apb_read(reg_status, status, err);
        end
    endtask

    // M-extension results, including divide by zero and signed overflow.
    function automatic logic [xlen-1:0] expected_result(input logic [xlen-1:0] a,
                                                       input logic [xlen-1:0] b,
                                                       input div_op_e op);
        logic                   zero;
        logic                   overflow;
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic [xlen-1:0]        value;
        zero     = (b == '0);
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        sa       = a;
        sb       = b;
        case (op)
            op_divu: value = zero ? {xlen{1'b1}} : a / b;
            op_remu: value = zero ? a : a % b;
            op_div: begin
                if (zero) begin
                    value = {xlen{1'b1}};
                end else if (overflow) begin
                    value = a;
                end else begin
                    value = sa / sb;                // truncates toward zero.
                end
            end
            default: begin
                if (zero) begin
                    value = a;
                end else if (overflow) begin
                    value = '0;
                end else begin
                    value = sa % sb;                // sign of the dividend.
                end
            end
        endcase
        return value;
    endfunction

    task automatic add_vector(input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                              input div_op_e op, input logic [xlen-1:0] expected);
        vector_t v;
        v.dividend = a;
        v.divisor  = b;
        v.op       = op;
        v.expected = expected;
        vectors.push_back(v);
    endtask

    task automatic start_division(input vector_t v, output logic err);
        logic err_a;
        logic err_b;
        logic err_c;
        apb_write(reg_dividend, v.dividend, err_a);
        apb_write(reg_divisor, v.divisor, err_b);
        apb_write(reg_ctrl, 32'h100 | 32'(v.op), err_c);    // start bit with opcode.
        err = err_a | err_b | err_c;
    endtask

    task automatic run_vector(input int idx, input vector_t v);
        logic [xlen-1:0] status;
        logic [xlen-1:0] data;
        logic            err;
        int              errors_before;
        div_op_e         op;
        op            = v.op;
        errors_before = error_count;
        start_division(v, err);
        check_value("pslverr", 32'(err), '0);
        wait_done(status);
        apb_read(reg_result, data, err);
        check_value("result", data, v.expected);
        apb_read(reg_status, status, err);                  // zero flag lands after done.
        check_value("status.divide_by_zero", 32'(status[2]), 32'(v.divisor == '0));
        report_test($sformatf("%0d %s %h / %h", idx, op.name(), v.dividend, v.divisor),
                    errors_before);
    endtask

    task automatic run_protocol_checks();
        logic [xlen-1:0] data;
        logic            err;
        int              errors_before;
        vector_t         v;
        errors_before = error_count;
        apb_read(5'h14, data, err);
        check_value("pslverr", 32'(err), 32'd1);
        apb_write(reg_status, 32'h1, err);                  // status is read only.
        check_value("pslverr", 32'(err), 32'd1);
        report_test("unmapped and read-only access", errors_before);

        errors_before = error_count;
        v.dividend = 32'd1000;
        v.divisor  = 32'd7;
        v.op       = op_divu;
        v.expected = 32'd142;
        start_division(v, err);
        check_value("pslverr", 32'(err), '0);
        apb_write(reg_ctrl, 32'h100 | 32'(op_remu), err);
        check_value("pslverr", 32'(err), 32'd1);
        apb_read(reg_status, data, err);
        check_value("status.busy", 32'(data[0]), 32'd1);
        wait_done(data);
        check_value("status.busy", 32'(data[0]), '0);
        apb_read(reg_result, data, err);
        check_value("result", data, v.expected);
        report_test("start while busy", errors_before);
    endtask

    initial begin
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] r;
        div_op_e         op;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        void'($urandom(30));

        // dividend, divisor, opcode, expected result
        add_vector(32'h0000_0000, 32'h0000_0007, op_divu, 32'h0000_0000);
        add_vector(32'h0000_0000, 32'h0000_0007, op_remu, 32'h0000_0000);
        add_vector(32'h0000_3039, 32'h0000_0001, op_divu, 32'h0000_3039);
        add_vector(32'h0000_3039, 32'h0000_0001, op_remu, 32'h0000_0000);
        add_vector(32'h0000_0005, 32'h0000_0009, op_divu, 32'h0000_0000);
        add_vector(32'h0000_0005, 32'h0000_0009, op_remu, 32'h0000_0005);
        add_vector(32'hFFFF_FFFF, 32'h0000_0001, op_divu, 32'hFFFF_FFFF);
        add_vector(32'hFFFF_FFFF, 32'h0000_0001, op_remu, 32'h0000_0000);
        add_vector(32'hFFFF_FFFF, 32'hFFFF_FFFF, op_divu, 32'h0000_0001);
        add_vector(32'hFFFF_FFFF, 32'h0000_000A, op_divu, 32'h1999_9999);
        add_vector(32'hFFFF_FFFF, 32'h0000_000A, op_remu, 32'h0000_0005);
        add_vector(32'h0000_0005, 32'h0000_0003, op_divu, 32'h0000_0001);
        add_vector(32'h0000_0005, 32'h0000_0003, op_remu, 32'h0000_0002);
        add_vector(32'h0000_0007, 32'h0000_0002, op_div,  32'h0000_0003);
        add_vector(32'h0000_0007, 32'h0000_0002, op_rem,  32'h0000_0001);
        add_vector(32'hFFFF_FFF9, 32'h0000_0002, op_div,  32'hFFFF_FFFD);
        add_vector(32'hFFFF_FFF9, 32'h0000_0002, op_rem,  32'hFFFF_FFFF);
        add_vector(32'h0000_0007, 32'hFFFF_FFFE, op_div,  32'hFFFF_FFFD);
        add_vector(32'h0000_0007, 32'hFFFF_FFFE, op_rem,  32'h0000_0001);
        add_vector(32'hFFFF_FFF9, 32'hFFFF_FFFE, op_div,  32'h0000_0003);
        add_vector(32'hFFFF_FFF9, 32'hFFFF_FFFE, op_rem,  32'hFFFF_FFFF);
        add_vector(32'h0000_1234, 32'h0000_0000, op_div,  32'hFFFF_FFFF);
        add_vector(32'h0000_1234, 32'h0000_0000, op_divu, 32'hFFFF_FFFF);
        add_vector(32'h0000_1234, 32'h0000_0000, op_rem,  32'h0000_1234);
        add_vector(32'h0000_1234, 32'h0000_0000, op_remu, 32'h0000_1234);
        add_vector(32'hFFFF_FF00, 32'h0000_0000, op_rem,  32'hFFFF_FF00);
        add_vector(32'hFFFF_FF00, 32'h0000_0000, op_div,  32'hFFFF_FFFF);
        add_vector(32'h8000_0000, 32'hFFFF_FFFF, op_div,  32'h8000_0000);
        add_vector(32'h8000_0000, 32'hFFFF_FFFF, op_rem,  32'h0000_0000);
        add_vector(32'h8000_0000, 32'h0000_0001, op_div,  32'h8000_0000);

        // random divisors get a random right shift so small ones show up too
        for (int i = 0; i < random_rows; i++) begin
            a  = $urandom;
            r  = $urandom;
            b  = $urandom >> r[4:0];
            op = div_op_e'(r[9:8]);
            add_vector(a, b, op, expected_result(a, b, op));
        end

        repeat (10) @(negedge clk);
        rst = 1'b0;

        foreach (vectors[i]) begin
            run_vector(i, vectors[i]);
        end
        run_protocol_checks();

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        finish_run(fail_count == 0);
    end

endmodule

`default_nettype wire

//--- files.f
src/div_pkg.sv
src/div_apb_regs.sv
src/div_control.sv
src/div_operand_prep.sv
src/div_radix4_core.sv
src/div_result_fix.sv
src/div_top.sv
verification/div_tb.sv

//--- Makefile
# Verilator build and run for the APB divider

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = div_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
